// ==== flist.f ====
+incdir+src
src/clint_pkg.sv
src/bus_interconnect.sv
src/clint.sv
src/scratch_ram.sv
src/clint_soc.sv
tb/clint_soc_asserts.sv
tb/clint_soc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f flist.f --top-module clint_soc_tb -Mdir obj_dir -o clint_soc_sim

output="$(./obj_dir/clint_soc_sim)" || true
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// ==== src/bus_interconnect.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_params.svh"

module bus_interconnect (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 m0_valid,
  input  clint_pkg::bus_addr_t m0_addr,
  input  clint_pkg::bus_data_t m0_wdata,
  input  clint_pkg::bus_strb_t m0_wstrb,
  output clint_pkg::bus_data_t m0_rdata,
  output logic                 m0_ready,
  input  logic                 m1_valid,
  input  clint_pkg::bus_addr_t m1_addr,
  input  clint_pkg::bus_data_t m1_wdata,
  input  clint_pkg::bus_strb_t m1_wstrb,
  output clint_pkg::bus_data_t m1_rdata,
  output logic                 m1_ready,
  output logic                 clint_valid,
  output logic                 ram_valid,
  output clint_pkg::bus_addr_t slave_addr,
  output clint_pkg::bus_data_t slave_wdata,
  output clint_pkg::bus_strb_t slave_wstrb,
  input  clint_pkg::bus_data_t clint_rdata,
  input  logic                 clint_ready,
  input  clint_pkg::bus_data_t ram_rdata,
  input  logic                 ram_ready
);
  import clint_pkg::*;

  logic busy;        // A transfer is in flight.
  logic grant;       // Master owning the bus, 0 or 1.
  logic last;        // Winner of the previous grant.
  logic tgt_clint;
  logic tgt_ram;
  logic none_ready;  // Unmapped access completes here.
  logic pick;
  logic take;
  logic done;
  logic hit_clint;
  logic hit_ram;
  logic rsp_ready;
  bus_data_t rsp_rdata;
  bus_addr_t pick_addr;

  // ----------------------------------------
  // Arbitration and decode
  // ----------------------------------------

  // On a tie the master not granted last wins.
  assign pick = (m0_valid && m1_valid) ? ~last : m1_valid;
  assign pick_addr = pick ? m1_addr : m0_addr;

  assign hit_clint = (pick_addr >= `CLINT_BASE) &&
                     (pick_addr < (`CLINT_BASE + `CLINT_SIZE));
  assign hit_ram = (pick_addr >= `RAM_BASE) &&
                   (pick_addr < (`RAM_BASE + `RAM_SIZE));

  assign done = busy && rsp_ready;
  assign take = (!busy || done) && (m0_valid || m1_valid);

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy        <= 1'b0;
      grant       <= 1'b0;
      last        <= 1'b1; // m0 first after reset.
      tgt_clint   <= 1'b0;
      tgt_ram     <= 1'b0;
      none_ready  <= 1'b0;
      clint_valid <= 1'b0;
      ram_valid   <= 1'b0;
    end else begin
      clint_valid <= 1'b0;
      ram_valid   <= 1'b0;
      none_ready  <= 1'b0;
      if (done) begin
        busy <= 1'b0;
      end
      if (take) begin
        busy        <= 1'b1;
        grant       <= pick;
        last        <= pick;
        tgt_clint   <= hit_clint;
        tgt_ram     <= hit_ram;
        clint_valid <= hit_clint; // Single cycle pulse.
        ram_valid   <= hit_ram;
        none_ready  <= !hit_clint && !hit_ram;
      end
    end
  end

  // Request payload, held for the whole transfer.
  always_ff @(posedge clock) begin
    if (take) begin
      slave_addr  <= pick_addr;
      slave_wdata <= pick ? m1_wdata : m0_wdata;
      slave_wstrb <= pick ? m1_wstrb : m0_wstrb;
    end
  end

  // ----------------------------------------
  // Response routing
  // ----------------------------------------
  assign rsp_ready = (tgt_clint && clint_ready) || (tgt_ram && ram_ready) || none_ready;
  assign rsp_rdata = tgt_clint ? clint_rdata : (tgt_ram ? ram_rdata : '0);

  assign m0_ready = done && !grant;
  assign m1_ready = done && grant;
  assign m0_rdata = rsp_rdata; // Qualified by ready.
  assign m1_rdata = rsp_rdata;

endmodule

`default_nettype wire

// ==== src/clint.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_params.svh"

module clint (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid,
  input  clint_pkg::bus_addr_t addr,
  input  clint_pkg::bus_data_t wdata,
  input  clint_pkg::bus_strb_t wstrb,
  output clint_pkg::bus_data_t rdata,
  output logic                 ready,
  output logic [63:0]          mtime,
  output logic                 msip,
  output logic                 mtip
);
  import clint_pkg::*;

  localparam int tick_half = `CLINT_TICK_DIVIDE / 2;
  localparam int cnt_w = $clog2(tick_half + 1);
  localparam logic [15:0] msip_ofs = `CLINT_MSIP_OFS;
  localparam logic [15:0] mtimecmp_ofs = `CLINT_MTIMECMP_OFS;
  localparam logic [15:0] mtime_ofs = `CLINT_MTIME_OFS;

  logic [15:0] ofs;
  logic sel_msip;
  logic sel_mtimecmp;
  logic sel_mtime;
  logic write;
  logic [cnt_w-1:0] count;
  logic tick;
  timer_word_t mtime_q;
  timer_word_t mtimecmp_q;
  timer_word_t wr_word;

  // Each strobed half replaces the matching half of the register.
  function automatic timer_word_t merge_halves(timer_word_t cur, timer_word_t upd,
                                               bus_strb_t strb);
    timer_word_t res;
    res = cur;
    if (|strb[`STRB_W/2-1:0]) begin
      res.half.lo = upd.half.lo;
    end
    if (|strb[`STRB_W-1:`STRB_W/2]) begin
      res.half.hi = upd.half.hi;
    end
    return res;
  endfunction

  // ----------------------------------------
  // Offset decode
  // ----------------------------------------
  assign ofs = addr[15:0];
  assign write = |wstrb;
  assign wr_word = wdata;

  // Word granular, so either half of a word hits the register.
  assign sel_msip = ofs[15:3] == msip_ofs[15:3];
  assign sel_mtimecmp = ofs[15:3] == mtimecmp_ofs[15:3];
  assign sel_mtime = ofs[15:3] == mtime_ofs[15:3];

  // ----------------------------------------
  // Prescaler and timer
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == cnt_w'(tick_half - 1)) begin
      count <= '0;
      tick  <= 1'b1;
    end else begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1; // Far future, mtip stays low.
      msip       <= 1'b0;
    end else begin
      if (tick) begin
        mtime_q.full <= mtime_q.full + 64'd1;
      end
      if (valid && write && sel_mtime) begin
        mtime_q <= merge_halves(mtime_q, wr_word, wstrb); // Wins over the step.
      end
      if (valid && write && sel_mtimecmp) begin
        mtimecmp_q <= merge_halves(mtimecmp_q, wr_word, wstrb);
      end
      if (valid && write && sel_msip && wstrb[0]) begin
        msip <= wdata[0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtip <= 1'b0;
    end else begin
      mtip <= mtime_q.full >= mtimecmp_q.full;
    end
  end

  // ----------------------------------------
  // Bus response
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      if (write) begin
        rdata <= '0;
      end else if (sel_msip) begin
        rdata <= {{(`DATA_W-1){1'b0}}, msip};
      end else if (sel_mtimecmp) begin
        rdata <= mtimecmp_q.full;
      end else if (sel_mtime) begin
        rdata <= mtime_q.full;
      end else begin
        rdata <= '0; // Hole in the window.
      end
    end
  end

  assign mtime = mtime_q.full;

endmodule

`default_nettype wire

// ==== src/clint_params.svh ====
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8

// ----------------------------------------
// Address map
// ----------------------------------------
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000 // 64 KiB window.
`define RAM_BASE 32'h8000_0000
`define RAM_WORDS 64
`define RAM_SIZE (`RAM_WORDS * `STRB_W) // Bytes.

`define CLINT_MSIP_OFS 16'h0000
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS 16'hBFF8

`define CLINT_TICK_DIVIDE 10 // Clocks per full tick period.

`endif

// ==== src/clint_pkg.sv ====
`default_nettype none

`include "clint_params.svh"

package clint_pkg;

  // Bus side names.
  typedef logic [`ADDR_W-1:0] bus_addr_t;
  typedef logic [`DATA_W-1:0] bus_data_t;
  typedef logic [`STRB_W-1:0] bus_strb_t;

  // Timer word, seen whole or as two 32-bit halves.
  typedef union packed {
    logic [`DATA_W-1:0] full;
    struct packed {
      logic [`DATA_W/2-1:0] hi;
      logic [`DATA_W/2-1:0] lo;
    } half;
  } timer_word_t;

endpackage

`default_nettype wire

// ==== src/clint_soc.sv ====
`timescale 1ns/10ps
`default_nettype none

module clint_soc (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 m0_valid,
  input  clint_pkg::bus_addr_t m0_addr,
  input  clint_pkg::bus_data_t m0_wdata,
  input  clint_pkg::bus_strb_t m0_wstrb,
  output clint_pkg::bus_data_t m0_rdata,
  output logic                 m0_ready,
  input  logic                 m1_valid,
  input  clint_pkg::bus_addr_t m1_addr,
  input  clint_pkg::bus_data_t m1_wdata,
  input  clint_pkg::bus_strb_t m1_wstrb,
  output clint_pkg::bus_data_t m1_rdata,
  output logic                 m1_ready,
  output logic [63:0]          clint_mtime,
  output logic                 clint_msip,
  output logic                 clint_mtip
);
  import clint_pkg::*;

  // ----------------------------------------
  // Shared slave bus
  // ----------------------------------------
  logic clint_valid;
  logic clint_ready;
  logic ram_valid;
  logic ram_ready;
  bus_addr_t slave_addr;
  bus_data_t slave_wdata;
  bus_strb_t slave_wstrb;
  bus_data_t clint_rdata;
  bus_data_t ram_rdata;

  bus_interconnect bus_interconnect_i (
    .clock       (clock),
    .reset       (reset),
    .m0_valid    (m0_valid),
    .m0_addr     (m0_addr),
    .m0_wdata    (m0_wdata),
    .m0_wstrb    (m0_wstrb),
    .m0_rdata    (m0_rdata),
    .m0_ready    (m0_ready),
    .m1_valid    (m1_valid),
    .m1_addr     (m1_addr),
    .m1_wdata    (m1_wdata),
    .m1_wstrb    (m1_wstrb),
    .m1_rdata    (m1_rdata),
    .m1_ready    (m1_ready),
    .clint_valid (clint_valid),
    .ram_valid   (ram_valid),
    .slave_addr  (slave_addr),
    .slave_wdata (slave_wdata),
    .slave_wstrb (slave_wstrb),
    .clint_rdata (clint_rdata),
    .clint_ready (clint_ready),
    .ram_rdata   (ram_rdata),
    .ram_ready   (ram_ready)
  );

  clint clint_i (
    .clock (clock),
    .reset (reset),
    .valid (clint_valid),
    .addr  (slave_addr),
    .wdata (slave_wdata),
    .wstrb (slave_wstrb),
    .rdata (clint_rdata),
    .ready (clint_ready),
    .mtime (clint_mtime),
    .msip  (clint_msip),
    .mtip  (clint_mtip)
  );

  scratch_ram scratch_ram_i (
    .clock (clock),
    .reset (reset),
    .valid (ram_valid),
    .addr  (slave_addr),
    .wdata (slave_wdata),
    .wstrb (slave_wstrb),
    .rdata (ram_rdata),
    .ready (ram_ready)
  );

endmodule

`default_nettype wire

// ==== src/scratch_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_params.svh"

module scratch_ram (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid,
  input  clint_pkg::bus_addr_t addr,
  input  clint_pkg::bus_data_t wdata,
  input  clint_pkg::bus_strb_t wstrb,
  output clint_pkg::bus_data_t rdata,
  output logic                 ready
);
  import clint_pkg::*;

  localparam int idx_w = $clog2(`RAM_WORDS);

  bus_data_t mem [0:`RAM_WORDS-1];
  logic [idx_w-1:0] index;

  assign index = addr[idx_w+2:3]; // Byte address to word.

  // Read returns the word before this cycle's write.
  always_ff @(posedge clock) begin
    if (valid) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (wstrb[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
      rdata <= mem[index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;
    end
  end

endmodule

`default_nettype wire

// ==== tb/clint_soc_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_params.svh"

module clint_soc_asserts (
  input logic                 clock,
  input logic                 reset,
  input logic                 m0_valid,
  input logic                 m0_ready,
  input logic                 m1_valid,
  input logic                 m1_ready,
  input logic                 clint_valid,
  input clint_pkg::bus_addr_t slave_addr,
  input clint_pkg::bus_data_t slave_wdata,
  input clint_pkg::bus_strb_t slave_wstrb,
  input logic [63:0]          clint_mtime,
  input logic                 clint_mtip
);
  import clint_pkg::*;

  localparam int tick_half = `CLINT_TICK_DIVIDE / 2;
  localparam logic [15:0] mtime_ofs = `CLINT_MTIME_OFS;
  localparam logic [15:0] mtimecmp_ofs = `CLINT_MTIMECMP_OFS;

  logic mtime_wr;
  logic mtimecmp_wr;
  logic mtime_wr_d;
  logic stepped;
  logic ge_d;
  logic m0_valid_d;
  logic m1_valid_d;
  logic [7:0] gap; // Clocks since the last step.
  logic [63:0] mtime_d;
  timer_word_t cmp_shadow;

  assign mtime_wr = clint_valid && (|slave_wstrb) && (slave_addr[15:3] == mtime_ofs[15:3]);
  assign mtimecmp_wr = clint_valid && (|slave_wstrb) &&
                       (slave_addr[15:3] == mtimecmp_ofs[15:3]);
  assign stepped = (clint_mtime != mtime_d) && !mtime_wr_d;

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime_d    <= '0;
      mtime_wr_d <= 1'b0;
      gap        <= 8'hff;
      cmp_shadow <= '1;
      ge_d       <= 1'b0;
      m0_valid_d <= 1'b0;
      m1_valid_d <= 1'b0;
    end else begin
      mtime_d    <= clint_mtime;
      mtime_wr_d <= mtime_wr;
      ge_d       <= clint_mtime >= cmp_shadow.full;
      m0_valid_d <= m0_valid;
      m1_valid_d <= m1_valid;
      if (stepped) begin
        gap <= 8'd1;
      end else if (gap != 8'hff) begin
        gap <= gap + 8'd1;
      end
      if (mtimecmp_wr && (|slave_wstrb[3:0])) begin
        cmp_shadow.half.lo <= slave_wdata[31:0];
      end
      if (mtimecmp_wr && (|slave_wstrb[7:4])) begin
        cmp_shadow.half.hi <= slave_wdata[63:32];
      end
    end
  end

  // ----------------------------------------
  // Timer and protocol properties
  // ----------------------------------------
  mtime_step: assert property (@(posedge clock) disable iff (!reset)
    !mtime_wr_d |-> ((clint_mtime == mtime_d) || (clint_mtime == mtime_d + 64'd1)))
    else $error("mtime moved by more than one step without a bus write");

  mtime_spacing: assert property (@(posedge clock) disable iff (!reset)
    stepped |-> (gap >= 8'(tick_half)))
    else $error("mtime stepped sooner than the prescaler period");

  mtip_follows: assert property (@(posedge clock) disable iff (!reset)
    clint_mtip == ge_d)
    else $error("mtip does not match last cycle's mtime compare");

  m0_ready_valid: assert property (@(posedge clock) disable iff (!reset)
    m0_ready |-> m0_valid_d)
    else $error("ready pulsed to master 0 without a raised valid");

  m1_ready_valid: assert property (@(posedge clock) disable iff (!reset)
    m1_ready |-> m1_valid_d)
    else $error("ready pulsed to master 1 without a raised valid");

endmodule

`default_nettype wire

// ==== tb/clint_soc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clint_params.svh"

module clint_soc_tb;
  import clint_pkg::*;

  localparam int clock_period = 40;
  localparam int tick_half = `CLINT_TICK_DIVIDE / 2;
  localparam bus_addr_t msip_addr = `CLINT_BASE + `CLINT_MSIP_OFS;
  localparam bus_addr_t mtimecmp_addr = `CLINT_BASE + `CLINT_MTIMECMP_OFS;
  localparam bus_addr_t mtime_addr = `CLINT_BASE + `CLINT_MTIME_OFS;
  localparam int timeout_clocks = 160 + (20 * tick_half + 40) + (3 * tick_half + 40) + 100;

  logic clock;
  logic reset;
  logic m0_valid;
  bus_addr_t m0_addr;
  bus_data_t m0_wdata;
  bus_strb_t m0_wstrb;
  bus_data_t m0_rdata;
  logic m0_ready;
  logic m1_valid;
  bus_addr_t m1_addr;
  bus_data_t m1_wdata;
  bus_strb_t m1_wstrb;
  bus_data_t m1_rdata;
  logic m1_ready;
  logic [63:0] clint_mtime;
  logic clint_msip;
  logic clint_mtip;
  int checks;
  int value_errors;
  int other_errors;
  logic [31:0] lfsr_state;
  bus_data_t ram_model [0:`RAM_WORDS-1];

  clint_soc clint_soc_i (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // Galois LFSR, one step per bit taken.
  function automatic bus_data_t random_bits(int count);
    bus_data_t word;
    logic bit_out;
    word = '0;
    for (int i = 0; i < count; i++) begin
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) begin
        lfsr_state = lfsr_state ^ 32'hd000_0001;
      end
      word = {word[`DATA_W-2:0], bit_out};
    end
    return word;
  endfunction

  task automatic check_value(string name, bus_data_t expected, bus_data_t actual);
    checks++;
    assert (actual == expected) else begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_range(string name, bus_data_t low, bus_data_t high, bus_data_t actual);
    checks++;
    assert (actual >= low && actual <= high) else begin
      value_errors++;
      $display("ERROR %s: expected %h to %h, actual %h", name, low, high, actual);
    end
  endtask

  task automatic drive_master(int port, logic valid, bus_addr_t addr, bus_data_t wdata,
                              bus_strb_t wstrb);
    if (port == 0) begin
      m0_valid = valid;
      m0_addr  = addr;
      m0_wdata = wdata;
      m0_wstrb = wstrb;
    end else begin
      m1_valid = valid;
      m1_addr  = addr;
      m1_wdata = wdata;
      m1_wstrb = wstrb;
    end
  endtask

  // Called on a falling edge; counts clock edges until ready.
  task automatic bus_access(input int port, input bus_addr_t addr, input bus_data_t wdata,
                            input bus_strb_t wstrb, output bus_data_t rdata, output int edges);
    logic seen;
    seen = 1'b0;
    edges = 0;
    drive_master(port, 1'b1, addr, wdata, wstrb);
    while (!seen && edges < 20) begin
      @(negedge clock);
      edges++;
      seen = (port == 0) ? m0_ready : m1_ready;
    end
    rdata = (port == 0) ? m0_rdata : m1_rdata;
    drive_master(port, 1'b0, addr, wdata, '0);
    assert (seen) else begin
      other_errors++;
      $display("Master %0d got no ready within 20 clocks at address %h.", port, addr);
    end
  endtask

  initial begin
    bus_data_t rd;
    bus_data_t rd1;
    bus_data_t written;
    int edges;
    int edges1;
    int waited;
    timer_word_t cmp_exp;
    timer_word_t half_wr;
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    lfsr_state = 32'hc437_1e80;
    reset = 1'b0;
    drive_master(0, 1'b0, '0, '0, '0);
    drive_master(1, 1'b0, '0, '0, '0);
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    @(negedge clock);

    // ----------------------------------------
    // Arbitration over the scratch RAM
    // ----------------------------------------
    ram_model[0] = random_bits(64);
    ram_model[1] = random_bits(64);
    fork
      bus_access(0, `RAM_BASE, ram_model[0], 8'hff, rd, edges);
      bus_access(1, `RAM_BASE + 8, ram_model[1], 8'hff, rd1, edges1);
    join
    check_value("tie after reset m0 edges", 64'd2, 64'(edges));
    check_value("tie after reset m1 edges", 64'd4, 64'(edges1));
    ram_model[2] = random_bits(64);
    bus_access(0, `RAM_BASE + 16, ram_model[2], 8'hff, rd, edges);
    check_value("single m0 edges", 64'd2, 64'(edges));
    fork
      bus_access(0, `RAM_BASE + 8, '0, '0, rd, edges);
      bus_access(1, `RAM_BASE + 16, '0, '0, rd1, edges1);
    join
    check_value("tie after m0 m1 edges", 64'd2, 64'(edges1));
    check_value("tie after m0 m0 edges", 64'd4, 64'(edges));
    check_value("ram read m0", ram_model[1], rd);
    check_value("ram read m1", ram_model[2], rd1);
    for (int i = 3; i < 8; i++) begin
      ram_model[i] = random_bits(64);
      bus_access(i % 2, `RAM_BASE + 8 * i, ram_model[i], 8'hff, rd, edges);
      bus_access(1 - i % 2, `RAM_BASE + 8 * i, '0, '0, rd, edges);
      check_value("ram cross read", ram_model[i], rd);
    end
    bus_access(1, 32'h4000_0000, '0, '0, rd, edges);
    check_value("unmapped rdata", '0, rd);
    check_value("unmapped edges", 64'd1, 64'(edges));

    // ----------------------------------------
    // CLINT registers
    // ----------------------------------------
    bus_access(0, msip_addr, 64'd1, 8'h01, rd, edges);
    check_value("msip set", 64'd1, {63'd0, clint_msip});
    bus_access(1, msip_addr, '0, '0, rd, edges);
    check_value("msip read", 64'd1, rd);
    bus_access(0, msip_addr, 64'd0, 8'h01, rd, edges);
    check_value("msip clear", 64'd0, {63'd0, clint_msip});
    bus_access(1, msip_addr, '0, '0, rd, edges);
    check_value("msip read cleared", 64'd0, rd);

    written = 64'h0000_0001_ffff_fff0; // Carries into the high half.
    bus_access(0, mtime_addr, written, 8'hff, rd, edges);
    bus_access(1, mtime_addr, '0, '0, rd, edges);
    check_range("mtime readback", written, written + 64'd2, rd);
    repeat (20 * tick_half) @(negedge clock);
    check_range("mtime after wait", rd + 64'd18, rd + 64'd22, clint_mtime);

    bus_access(1, mtime_addr, '0, '0, rd, edges);
    bus_access(0, mtimecmp_addr, rd + 64'd3, 8'hff, rd1, edges);
    check_value("mtip low after compare write", 64'd0, {63'd0, clint_mtip});
    waited = 0;
    while (!clint_mtip && waited < 3 * tick_half + 4) begin
      @(negedge clock);
      waited++;
    end
    assert (clint_mtip) else begin
      other_errors++;
      $display("mtip did not rise within %0d clocks of the compare write.", waited);
    end

    cmp_exp.full = 64'h1111_2222_3333_4444;
    bus_access(0, mtimecmp_addr, cmp_exp.full, 8'hff, rd, edges);
    half_wr.full = random_bits(64);
    bus_access(1, mtimecmp_addr, half_wr.full, 8'h0f, rd, edges);
    cmp_exp.half.lo = half_wr.half.lo;
    bus_access(0, mtimecmp_addr, '0, '0, rd, edges);
    check_value("mtimecmp lo write", cmp_exp.full, rd);
    half_wr.full = random_bits(64);
    bus_access(1, mtimecmp_addr, half_wr.full, 8'hf0, rd, edges);
    cmp_exp.half.hi = half_wr.half.hi;
    bus_access(0, mtimecmp_addr, '0, '0, rd, edges);
    check_value("mtimecmp hi write", cmp_exp.full, rd);

    $display("Checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(timeout_clocks * clock_period);
    $display("The run timed out after %0d clocks before all tests finished.", timeout_clocks);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

bind clint_soc clint_soc_asserts clint_soc_asserts_i (
  .clock(clock), .reset(reset),
  .m0_valid(m0_valid), .m0_ready(m0_ready), .m1_valid(m1_valid), .m1_ready(m1_ready),
  .clint_valid(clint_valid), .slave_addr(slave_addr),
  .slave_wdata(slave_wdata), .slave_wstrb(slave_wstrb),
  .clint_mtime(clint_mtime), .clint_mtip(clint_mtip)
);

`default_nettype wire
